/* dram_pkg.sv */
package dram_pkg;

    //////////////////////////////////////////////////
    // counter sizing
    //////////////////////////////////////////////////

    localparam int CNT_W = 12; // wait counter width.

    //////////////////////////////////////////////////
    // init FSM states
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        POWER_UP      = 4'd0,
        PRE_RESET     = 4'd1,
        RESET         = 4'd2,
        NOP           = 4'd3,
        LOAD_MODE_DLL = 4'd4,
        LOAD_BG0_REG3 = 4'd5,
        LOAD_BG1_REG6 = 4'd6,
        LOAD_BG1_REG5 = 4'd7,
        LOAD_BG1_REG4 = 4'd8,
        LOAD_BG0_REG2 = 4'd9,
        LOAD_BG0_REG1 = 4'd10,
        LOAD_BG0_REG0 = 4'd11,
        ZQ_CL         = 4'd12,
        IDLE          = 4'd13
    } init_state_t;

    //////////////////////////////////////////////////
    // DRAM command bus
    //////////////////////////////////////////////////

    // op codes carry a prefix so they do not collide with the FSM's NOP.
    typedef enum logic [1:0] {
        CMD_DESELECT = 2'd0,
        CMD_NOP      = 2'd1,
        CMD_MRS      = 2'd2,
        CMD_ZQCL     = 2'd3
    } dram_op_t;

    typedef struct packed {
        dram_op_t    op;
        logic [1:0]  bg;   // bank group.
        logic [1:0]  ba;   // bank.
        logic [17:0] addr;
    } dram_cmd_t;

    localparam dram_cmd_t DESELECT_CMD = '{
        op:   CMD_DESELECT,
        bg:   2'd0,
        ba:   2'd0,
        addr: 18'd0
    };

    typedef struct packed {
        logic reset_n;
        logic cke;
    } dram_pins_t;

endpackage

/* timing_counter.sv */
`timescale 1ns/1ps

module timing_counter #(
    parameter int W = 12
) (
    input  logic         CLK,
    input  logic         nRST,
    input  logic         clear,
    input  logic         enable,
    input  logic [W-1:0] term_value,
    output logic [W-1:0] count,
    output logic         flag
);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (clear) begin
            count <= '0; // clear wins over enable.
        end else if (enable) begin
            count <= count + 1'b1;
        end
    end

    // high on the final cycle of a wait.
    assign flag = (count == term_value - 1'b1);

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // a stopped counter must be parked away from its terminal value.
    flag_only_when_running: assert property (
        @(posedge CLK) disable iff (!nRST)
        flag |-> enable
    );

endmodule

/* init_sequencer.sv */
`timescale 1ns/1ps

module init_sequencer #(
    parameter int T_PWUP   = 2000,
    parameter int T_RST    = 2000,
    parameter int T_XPR    = 360,
    parameter int T_DLLK   = 768,
    parameter int T_MOD    = 24,
    parameter int T_ZQINIT = 1024
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  init,
    output dram_pkg::init_state_t state,
    output dram_pkg::dram_pins_t  pins,
    output logic                  init_done
);

    typedef logic [dram_pkg::CNT_W-1:0] cnt_t;

    dram_pkg::init_state_t next_state;
    dram_pkg::init_state_t follow_state;
    dram_pkg::dram_pins_t  next_pins;
    cnt_t                  term_value;
    logic                  cnt_clear;
    logic                  cnt_enable;
    logic                  next_cnt_enable;
    logic                  cnt_flag;
    logic                  next_init_done;

    timing_counter #(
        .W(dram_pkg::CNT_W)
    ) time_counter (
        .CLK       (CLK),
        .nRST      (nRST),
        .clear     (cnt_clear),
        .enable    (cnt_enable),
        .term_value(term_value),
        .count     (),
        .flag      (cnt_flag)
    );

    //////////////////////////////////////////////////
    // wait length and successor per state
    //////////////////////////////////////////////////

    always_comb begin
        term_value   = '0; // idle parks the counter off its terminal.
        follow_state = state;
        case (state)
            dram_pkg::POWER_UP: begin
                term_value   = cnt_t'(T_PWUP);
                follow_state = dram_pkg::PRE_RESET;
            end
            dram_pkg::PRE_RESET: begin
                term_value   = cnt_t'(T_RST);
                follow_state = dram_pkg::RESET;
            end
            dram_pkg::RESET: begin
                term_value   = cnt_t'(T_RST);
                follow_state = dram_pkg::NOP;
            end
            dram_pkg::NOP: begin
                term_value   = cnt_t'(T_XPR);
                follow_state = dram_pkg::LOAD_MODE_DLL;
            end
            dram_pkg::LOAD_MODE_DLL: begin
                term_value   = cnt_t'(T_DLLK);
                follow_state = dram_pkg::LOAD_BG0_REG3;
            end
            dram_pkg::LOAD_BG0_REG3: begin
                term_value   = cnt_t'(T_MOD);
                follow_state = dram_pkg::LOAD_BG1_REG6;
            end
            dram_pkg::LOAD_BG1_REG6: begin
                term_value   = cnt_t'(T_MOD);
                follow_state = dram_pkg::LOAD_BG1_REG5;
            end
            dram_pkg::LOAD_BG1_REG5: begin
                term_value   = cnt_t'(T_MOD);
                follow_state = dram_pkg::LOAD_BG1_REG4;
            end
            dram_pkg::LOAD_BG1_REG4: begin
                term_value   = cnt_t'(T_MOD);
                follow_state = dram_pkg::LOAD_BG0_REG2;
            end
            dram_pkg::LOAD_BG0_REG2: begin
                term_value   = cnt_t'(T_MOD);
                follow_state = dram_pkg::LOAD_BG0_REG1;
            end
            dram_pkg::LOAD_BG0_REG1: begin
                term_value   = cnt_t'(T_MOD);
                follow_state = dram_pkg::LOAD_BG0_REG0;
            end
            dram_pkg::LOAD_BG0_REG0: begin
                term_value   = cnt_t'(T_MOD);
                follow_state = dram_pkg::ZQ_CL;
            end
            dram_pkg::ZQ_CL: begin
                term_value   = cnt_t'(T_ZQINIT);
                follow_state = dram_pkg::IDLE;
            end
            default: ; // idle is terminal.
        endcase
    end

    //////////////////////////////////////////////////
    // sequencing
    //////////////////////////////////////////////////

    always_comb begin
        next_state      = state;
        next_cnt_enable = cnt_enable;
        next_init_done  = init_done;
        cnt_clear       = 1'b0;
        if (state == dram_pkg::POWER_UP && init) begin
            next_cnt_enable = 1'b1; // start the power-up wait.
        end
        if (cnt_flag) begin
            cnt_clear  = 1'b1;
            next_state = follow_state;
            if (state == dram_pkg::ZQ_CL) begin
                next_cnt_enable = 1'b0;
                next_init_done  = 1'b1;
            end
        end
    end

    // pin levels follow the state being entered.
    always_comb begin
        next_pins.reset_n = 1'b1;
        next_pins.cke     = 1'b1;
        case (next_state)
            dram_pkg::POWER_UP, dram_pkg::PRE_RESET: begin
                next_pins.reset_n = 1'b0;
                next_pins.cke     = 1'b0;
            end
            dram_pkg::RESET: begin
                next_pins.cke = 1'b0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= dram_pkg::POWER_UP;
            pins       <= '0;
            cnt_enable <= 1'b0;
            init_done  <= 1'b0;
        end else begin
            state      <= next_state;
            pins       <= next_pins;
            cnt_enable <= next_cnt_enable;
            init_done  <= next_init_done;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    done_only_in_idle: assert property (
        @(posedge CLK) disable iff (!nRST)
        init_done |-> (state == dram_pkg::IDLE)
    );

    idle_is_terminal: assert property (
        @(posedge CLK) disable iff (!nRST)
        (state == dram_pkg::IDLE) |=> (state == dram_pkg::IDLE)
    );

endmodule

/* init_cmd_encoder.sv */
`timescale 1ns/1ps

module init_cmd_encoder (
    input  logic                  CLK,
    input  logic                  nRST,
    input  dram_pkg::init_state_t state,
    output dram_pkg::dram_cmd_t   cmd,
    output logic                  cmd_valid
);

    dram_pkg::init_state_t prev_state;
    dram_pkg::dram_cmd_t   entry_cmd;
    logic                  is_cmd_state;
    logic                  entered;

    function automatic dram_pkg::dram_cmd_t mrs(
        input logic [1:0]  bg,
        input logic [1:0]  ba,
        input logic [17:0] addr
    );
        dram_pkg::dram_cmd_t c;
        c.op   = dram_pkg::CMD_MRS;
        c.bg   = bg;
        c.ba   = ba;
        c.addr = addr;
        return c;
    endfunction

    //////////////////////////////////////////////////
    // mode register table
    //////////////////////////////////////////////////

    always_comb begin
        entry_cmd    = dram_pkg::DESELECT_CMD;
        is_cmd_state = 1'b1;
        case (state)
            dram_pkg::LOAD_BG0_REG3: begin
                entry_cmd = mrs(2'd0, 2'd3, 18'h00000); // MR3.
            end
            dram_pkg::LOAD_BG1_REG6: begin
                entry_cmd = mrs(2'd1, 2'd2, 18'h00800); // MR6.
            end
            dram_pkg::LOAD_BG1_REG5: begin
                entry_cmd = mrs(2'd1, 2'd1, 18'h00400); // MR5.
            end
            dram_pkg::LOAD_BG1_REG4: begin
                entry_cmd = mrs(2'd1, 2'd0, 18'h00000); // MR4.
            end
            dram_pkg::LOAD_BG0_REG2: begin
                entry_cmd = mrs(2'd0, 2'd2, 18'h00008); // MR2.
            end
            dram_pkg::LOAD_BG0_REG1: begin
                entry_cmd = mrs(2'd0, 2'd1, 18'h00001); // MR1, DLL on.
            end
            dram_pkg::LOAD_BG0_REG0: begin
                entry_cmd = mrs(2'd0, 2'd0, 18'h00D20); // MR0.
            end
            dram_pkg::ZQ_CL: begin
                entry_cmd.op   = dram_pkg::CMD_ZQCL;
                entry_cmd.addr = 18'h00400; // A10 high selects long cal.
            end
            default: begin
                is_cmd_state = 1'b0;
            end
        endcase
    end

    // first cycle in a command state.
    assign entered = is_cmd_state && (state != prev_state);

    //////////////////////////////////////////////////
    // registered command strobe
    //////////////////////////////////////////////////

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            prev_state <= dram_pkg::POWER_UP;
            cmd_valid  <= 1'b0;
            cmd        <= dram_pkg::DESELECT_CMD;
        end else begin
            prev_state <= state;
            cmd_valid  <= entered;
            cmd        <= entered ? entry_cmd : dram_pkg::DESELECT_CMD;
        end
    end

    // each command state must hold for at least two cycles.
    single_cycle_strobe: assert property (
        @(posedge CLK) disable iff (!nRST)
        cmd_valid |=> !cmd_valid
    );

endmodule

/* dram_init_top.sv */
`timescale 1ns/1ps

module dram_init_top #(
    parameter int T_PWUP   = 2000,
    parameter int T_RST    = 2000,
    parameter int T_XPR    = 360,
    parameter int T_DLLK   = 768,
    parameter int T_MOD    = 24,
    parameter int T_ZQINIT = 1024
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  init,
    output logic                  init_done,
    output dram_pkg::dram_pins_t  pins,
    output dram_pkg::dram_cmd_t   cmd,
    output logic                  cmd_valid,
    output dram_pkg::init_state_t state
);

    //////////////////////////////////////////////////
    // bring-up FSM and wait timer
    //////////////////////////////////////////////////

    init_sequencer #(
        .T_PWUP  (T_PWUP),
        .T_RST   (T_RST),
        .T_XPR   (T_XPR),
        .T_DLLK  (T_DLLK),
        .T_MOD   (T_MOD),
        .T_ZQINIT(T_ZQINIT)
    ) sequencer (
        .CLK      (CLK),
        .nRST     (nRST),
        .init     (init),
        .state    (state),
        .pins     (pins),
        .init_done(init_done)
    );

    //////////////////////////////////////////////////
    // command bus
    //////////////////////////////////////////////////

    init_cmd_encoder encoder (
        .CLK      (CLK),
        .nRST     (nRST),
        .state    (state),
        .cmd      (cmd),
        .cmd_valid(cmd_valid)
    );

endmodule

/* tb_dram_init.sv */
`timescale 1ns/1ps

module tb_dram_init;

    localparam int T_PWUP   = 20;
    localparam int T_RST    = 20;
    localparam int T_XPR    = 12;
    localparam int T_DLLK   = 16;
    localparam int T_MOD    = 6;
    localparam int T_ZQINIT = 30;
    localparam int N_CMDS   = 8;
    localparam int N_WORDS  = 4 * N_CMDS + 1; // four columns per command plus the gap word.

    logic                  CLK;
    logic                  nRST;
    logic                  init;
    logic                  init_done;
    dram_pkg::dram_pins_t  pins;
    dram_pkg::dram_cmd_t   cmd;
    logic                  cmd_valid;
    dram_pkg::init_state_t state;

    logic [17:0]           td [0:N_WORDS-1];
    dram_pkg::dram_cmd_t   strobe_cmds[$];
    int                    strobe_cycs[$];
    dram_pkg::dram_cmd_t   idle_cmd = '{op: dram_pkg::CMD_DESELECT, bg: 2'd0, ba: 2'd0,
                                        addr: 18'd0};
    dram_pkg::dram_pins_t  prev_pins;
    logic                  prev_done;
    logic                  data_ready;
    int unsigned           lcg_state = 32'd12974;
    int                    cyc;
    int                    errors;
    int                    idle_gap;
    int                    reset_n_edges;
    int                    cke_edges;
    int                    reset_n_rise_cyc = -1;
    int                    cke_rise_cyc = -1;
    int                    done_cyc = -1;

    dram_init_top #(
        .T_PWUP  (T_PWUP),
        .T_RST   (T_RST),
        .T_XPR   (T_XPR),
        .T_DLLK  (T_DLLK),
        .T_MOD   (T_MOD),
        .T_ZQINIT(T_ZQINIT)
    ) UUT (
        .CLK      (CLK),
        .nRST     (nRST),
        .init     (init),
        .init_done(init_done),
        .pins     (pins),
        .cmd      (cmd),
        .cmd_valid(cmd_valid),
        .state    (state)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK) cyc <= cyc + 1; // posedge count for the negedge checks.

    //////////////////////////////////////////////////
    // compare tasks and helpers
    //////////////////////////////////////////////////

    task automatic check_cmd(input string name, input dram_pkg::dram_cmd_t exp,
                             input dram_pkg::dram_cmd_t act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_pins(input string name, input dram_pkg::dram_pins_t exp,
                              input dram_pkg::dram_pins_t act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_state(input string name, input dram_pkg::init_state_t exp,
                               input dram_pkg::init_state_t act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("ERR %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // one command from its four file columns.
    function automatic dram_pkg::dram_cmd_t expected_cmd(input int i);
        dram_pkg::dram_cmd_t c;
        c.op   = dram_pkg::dram_op_t'(td[4*i][1:0]);
        c.bg   = td[4*i+1][1:0];
        c.ba   = td[4*i+2][1:0];
        c.addr = td[4*i+3];
        return c;
    endfunction

    //////////////////////////////////////////////////
    // output monitor
    //////////////////////////////////////////////////

    always @(negedge CLK) begin
        if (nRST) begin
            if (pins.reset_n !== prev_pins.reset_n) begin
                reset_n_edges++;
                reset_n_rise_cyc = cyc;
            end
            if (pins.cke !== prev_pins.cke) begin
                cke_edges++;
                cke_rise_cyc = cyc;
            end
            if (cmd_valid === 1'b1) begin
                strobe_cmds.push_back(cmd);
                strobe_cycs.push_back(cyc);
            end else begin
                check_cmd("deselect between strobes", idle_cmd, cmd);
            end
            if (init_done === 1'b1 && prev_done !== 1'b1) begin
                done_cyc = cyc;
            end
            if (prev_done === 1'b1 && init_done !== 1'b1) begin
                errors++;
                $display("init_done dropped after it had risen, cycle %0d", cyc);
            end
        end
        prev_pins = pins;
        prev_done = init_done;
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        int i;
        int n_extra;
        int gap;
        CLK  = 1'b0;
        nRST <= 1'b0;
        init <= 1'b0;
        $readmemh("dram_init_testdata.txt", td);
        if ($isunknown(td[N_WORDS-1])) begin
            errors++;
            $display("data file dram_init_testdata.txt is missing or incomplete");
        end
        idle_gap   = int'(td[N_WORDS-1]);
        data_ready = 1'b1;

        repeat (8) begin
            @(negedge CLK);
            check_bit("cmd_valid in reset", 1'b0, cmd_valid);
            check_bit("init_done in reset", 1'b0, init_done);
            check_pins("pins in reset", 2'b00, pins);
        end
        @(posedge CLK);
        nRST <= 1'b1;

        // no init yet, so nothing may move.
        repeat (idle_gap) begin
            @(negedge CLK);
            check_state("state before init", dram_pkg::POWER_UP, state);
            check_bit("strobe before init", 1'b0, cmd_valid);
            check_bit("init_done before init", 1'b0, init_done);
            check_pins("pins before init", 2'b00, pins);
        end

        @(posedge CLK);
        init <= 1'b1;
        @(posedge CLK);
        init <= 1'b0;
        @(negedge CLK);
        i = cyc; // edge that samples the strobe.

        while (init_done !== 1'b1) @(negedge CLK);
        @(negedge CLK);

        check_cycles("reset_n edge count", 1, reset_n_edges);
        check_cycles("cke edge count", 1, cke_edges);
        check_cycles("reset_n rise cycle", i + T_PWUP + T_RST, reset_n_rise_cyc);
        check_cycles("cke rise cycle", reset_n_rise_cyc + T_RST, cke_rise_cyc);
        check_cycles("command strobe count", N_CMDS, strobe_cmds.size());
        for (i = 0; i < N_CMDS && i < strobe_cmds.size(); i++) begin
            check_cmd($sformatf("command %0d", i), expected_cmd(i), strobe_cmds[i]);
            if (i == 0) begin
                check_cycles("first strobe cycle", cke_rise_cyc + T_XPR + T_DLLK + 1,
                             strobe_cycs[0]);
            end else begin
                check_cycles($sformatf("strobe %0d spacing", i), strobe_cycs[i-1] + T_MOD,
                             strobe_cycs[i]);
            end
        end
        if (strobe_cycs.size() == N_CMDS) begin
            check_cycles("init_done rise cycle", strobe_cycs[N_CMDS-1] + T_ZQINIT - 1,
                         done_cyc);
        end

        // late init strobes must be ignored in IDLE.
        n_extra = 1 + int'(next_random() % 4);
        for (i = 0; i < n_extra; i++) begin
            gap = 2 + int'(next_random() % 8);
            repeat (gap) @(posedge CLK);
            init <= 1'b1;
            @(posedge CLK);
            init <= 1'b0;
        end
        repeat (2 * T_MOD + 4) begin
            @(negedge CLK);
            check_bit("init_done held", 1'b1, init_done);
            check_pins("pins held", 2'b11, pins);
            check_state("state held", dram_pkg::IDLE, state);
        end
        check_cycles("strobes after idle", N_CMDS, strobe_cmds.size());
        check_cycles("reset_n edges after idle", 1, reset_n_edges);
        check_cycles("cke edges after idle", 1, cke_edges);

        $display("checks done: %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    //////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////

    initial begin
        int limit;
        wait (data_ready === 1'b1);
        limit = T_PWUP + 2 * T_RST + T_XPR + T_DLLK + 7 * T_MOD + T_ZQINIT + idle_gap + 200;
        #(limit * 10);
        $display("timeout, the run was still going after %0d cycles", limit);
        $display("checks done: %0d errors", errors);
        $display("Test failed");
        $finish;
    end

endmodule

/* dram_init_testdata.txt */
// columns: kind (2 = MRS, 3 = ZQCL), bank group, bank, address; all hex
// the last word is the idle gap in cycles (hex) before the init strobe
2 0 3 00000 // MR3
2 1 2 00800 // MR6
2 1 1 00400 // MR5
2 1 0 00000 // MR4
2 0 2 00008 // MR2
2 0 1 00001 // MR1
2 0 0 00D20 // MR0
3 0 0 00400 // ZQCL, A10 set
20

/* files.f */
dram_pkg.sv
timing_counter.sv
init_sequencer.sv
init_cmd_encoder.sv
dram_init_top.sv
tb_dram_init.sv

/* Makefile */
TOP = tb_dram_init

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
